//--- source/periph_cfg.svh
// Peripheral subsystem configuration
// Bus widths, memory map, RNG FIFO sizing and the error word

`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Bus widths
`define PERIPH_DATA_W     32
`define PERIPH_ADDR_W     32
`define PERIPH_BE_W       4

// Memory map
`define PERIPH_BOOT_BASE  32'h0001_0000
`define PERIPH_BOOT_LEN   32'h400        // 256 words
`define PERIPH_GPIO_BASE  32'h4000_0000
`define PERIPH_GPIO_LEN   32'h40

// Random-number source
`define PERIPH_RNG_DEPTH  8
`define PERIPH_LFSR_SEED  32'h0000_0001
`define PERIPH_LFSR_TAPS  32'h8020_0003  // Galois form

`define PERIPH_ERR_WORD   32'hDEADBEEF

`endif

//--- source/periph_pkg.sv
// Peripheral subsystem types
// Request targets and GPIO register indices

`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------
    // Address decoder target
    // ------------------------------------------------------------
    typedef enum logic [1:0]
    {
        REGION_BOOT,
        REGION_GPIO,
        REGION_NONE
    } region_e;

    // ------------------------------------------------------------
    // GPIO register index, from address bits 5:3
    // ------------------------------------------------------------
    typedef enum logic [2:0]
    {
        GPIO_SWITCH_LED = 3'd0,
        GPIO_RNG_DATA   = 3'd2,
        GPIO_RNG_STATUS = 3'd3
    } gpio_reg_e;

endpackage

`default_nettype wire

//--- source/periph_bus_if.sv
// Peripheral request bus
// One-cycle strobe request from the decoder, registered read data back

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

interface periph_bus_if;

    logic                      req;    // One-cycle request strobe
    logic                      we;
    logic [`PERIPH_ADDR_W-1:0] addr;   // Full address, device uses low bits
    logic [`PERIPH_BE_W-1:0]   be;
    logic [`PERIPH_DATA_W-1:0] wdata;
    logic [`PERIPH_DATA_W-1:0] rdata;  // Valid the cycle after a read

    // Decoder side
    modport host (output req, we, addr, be, wdata, input rdata);

    // Device side
    modport device (input req, we, addr, be, wdata, output rdata);

endinterface

`default_nettype wire

//--- source/periph_rng_fifo.sv
// Hardware random-number source
// Galois LFSR that keeps a small circular FIFO topped up

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_rng_fifo
(
    input  wire logic                                      clk_i,
    input  wire logic                                      reset_i,
    input  wire logic                                      pop_i,
    output      logic [`PERIPH_DATA_W-1:0]                 head_o,
    output      logic [$clog2(`PERIPH_RNG_DEPTH + 1)-1:0]  count_o,
    output      logic                                      full_o,
    output      logic                                      empty_o
);

    localparam int DEPTH = `PERIPH_RNG_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`PERIPH_DATA_W-1:0] lfsr_q;
    logic [`PERIPH_DATA_W-1:0] lfsr_next;
    logic [`PERIPH_DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count_q;
    logic                      push;
    logic                      pop_ok;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign count_o = count_q;
    assign head_o  = mem[rd_ptr];

    assign push   = !full_o;            // Refill whenever there is room
    assign pop_ok = pop_i && !empty_o;  // Pop on empty is dropped

    // Shift right, fold in the taps when a one drops out
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ `PERIPH_LFSR_TAPS) : (lfsr_q >> 1);

    // ------------------------------------------------------------
    // Generator and pointers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            lfsr_q  <= `PERIPH_LFSR_SEED;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (push)
            begin
                lfsr_q <= lfsr_next;
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop_ok)
                count_q <= count_q + 1'b1;
            else if (pop_ok && !push)
                count_q <= count_q - 1'b1;
        end
    end

    // Storage, current state goes in before the step
    always_ff @(posedge clk_i)
    begin
        if (push)
            mem[wr_ptr] <= lfsr_q;
    end

endmodule

`default_nettype wire

//--- source/periph_bootram.sv
// Boot RAM
// Word memory with byte-lane writes and a registered read port

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_bootram
(
    input  wire logic    clk_i,
    periph_bus_if.device bus
);

    localparam int DEPTH = `PERIPH_BOOT_LEN / 4;
    localparam int IDX_W = $clog2(DEPTH);

    logic [`PERIPH_DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]          idx;

    assign idx = bus.addr[IDX_W+1:2];  // Word index

    // ------------------------------------------------------------
    // Write lanes and read register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (bus.req)
        begin
            if (bus.we)
            begin
                for (int lane = 0; lane < `PERIPH_BE_W; lane++)
                begin
                    if (bus.be[lane])
                        mem[idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
                end
            end
            else
            begin
                bus.rdata <= mem[idx];  // Seen by the decoder next cycle
            end
        end
    end

endmodule

`default_nettype wire

//--- source/periph_gpio_regs.sv
// GPIO register block
// LED output, DIP switch input and access to the hardware RNG FIFO

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_gpio_regs
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    input  wire logic [7:0] switches_i,
    output      logic [7:0] leds_o,
    periph_bus_if.device    bus
);
    import periph_pkg::*;

    localparam int CNT_W = $clog2(`PERIPH_RNG_DEPTH + 1);

    gpio_reg_e                 reg_sel;
    logic                      pop;
    logic [`PERIPH_DATA_W-1:0] rng_head;
    logic [CNT_W-1:0]          rng_count;
    logic                      rng_full;
    logic                      rng_empty;

    assign reg_sel = gpio_reg_e'(bus.addr[5:3]);

    // A write to the data register consumes the head
    assign pop = bus.req && bus.we && (reg_sel == GPIO_RNG_DATA);

    periph_rng_fifo i_rng_fifo
    (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .pop_i   (pop),
        .head_o  (rng_head),
        .count_o (rng_count),
        .full_o  (rng_full),
        .empty_o (rng_empty)
    );

    // ------------------------------------------------------------
    // LED register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            leds_o <= '0;
        else if (bus.req && bus.we && reg_sel == GPIO_SWITCH_LED && bus.be[0])
            leds_o <= bus.wdata[7:0];
    end

    // Registered read data, one cycle after the request
    always_ff @(posedge clk_i)
    begin
        if (bus.req && !bus.we)
        begin
            case (reg_sel)
                GPIO_SWITCH_LED: bus.rdata <= {{(`PERIPH_DATA_W-8){1'b0}}, switches_i};
                GPIO_RNG_DATA:   bus.rdata <= rng_head;  // Peek, no pop
                GPIO_RNG_STATUS:
                    bus.rdata <= {rng_full, rng_empty,
                                  {(`PERIPH_DATA_W-2-CNT_W){1'b0}}, rng_count};
                default:         bus.rdata <= `PERIPH_ERR_WORD;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/periph_addr_decode.sv
// Peripheral address decoder
// Routes each request to the boot RAM or GPIO block and selects the read data

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_addr_decode
(
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      req_i,
    input  wire logic                      we_i,
    input  wire logic [`PERIPH_ADDR_W-1:0] addr_i,
    input  wire logic [`PERIPH_BE_W-1:0]   be_i,
    input  wire logic [`PERIPH_DATA_W-1:0] wdata_i,
    output      logic [`PERIPH_DATA_W-1:0] rdata_o,
    output      logic                      rvalid_o,
    periph_bus_if.host                     boot_bus,
    periph_bus_if.host                     gpio_bus
);
    import periph_pkg::*;

    region_e region;
    region_e region_q;    // Target of the previous cycle's request
    logic    rd_q;

    // ------------------------------------------------------------
    // Address windows
    // ------------------------------------------------------------
    always_comb
    begin
        if (addr_i >= `PERIPH_BOOT_BASE && addr_i < `PERIPH_BOOT_BASE + `PERIPH_BOOT_LEN)
            region = REGION_BOOT;
        else if (addr_i >= `PERIPH_GPIO_BASE && addr_i < `PERIPH_GPIO_BASE + `PERIPH_GPIO_LEN)
            region = REGION_GPIO;
        else
            region = REGION_NONE;
    end

    // Strobe goes to the selected device only
    assign boot_bus.req   = req_i && (region == REGION_BOOT);
    assign boot_bus.we    = we_i;
    assign boot_bus.addr  = addr_i;
    assign boot_bus.be    = be_i;
    assign boot_bus.wdata = wdata_i;

    assign gpio_bus.req   = req_i && (region == REGION_GPIO);
    assign gpio_bus.we    = we_i;
    assign gpio_bus.addr  = addr_i;
    assign gpio_bus.be    = be_i;
    assign gpio_bus.wdata = wdata_i;

    // ------------------------------------------------------------
    // Response path
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            region_q <= REGION_NONE;
            rd_q     <= 1'b0;
        end
        else
        begin
            region_q <= region;
            rd_q     <= req_i && !we_i;  // Writes get no response
        end
    end

    assign rvalid_o = rd_q;

    always_comb
    begin
        case (region_q)
            REGION_BOOT: rdata_o = boot_bus.rdata;
            REGION_GPIO: rdata_o = gpio_bus.rdata;
            default:     rdata_o = `PERIPH_ERR_WORD;
        endcase
    end

endmodule

`default_nettype wire

//--- source/periph_top.sv
// Peripheral subsystem top level
// Strobe bus in, boot RAM and GPIO block behind a single address decoder

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_top
(
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      req_i,
    input  wire logic                      we_i,
    input  wire logic [`PERIPH_ADDR_W-1:0] addr_i,
    input  wire logic [`PERIPH_BE_W-1:0]   be_i,
    input  wire logic [`PERIPH_DATA_W-1:0] wdata_i,
    input  wire logic [7:0]                switches_i,
    output      logic [`PERIPH_DATA_W-1:0] rdata_o,
    output      logic                      rvalid_o,
    output      logic [7:0]                leds_o
);

    periph_bus_if boot_bus ();
    periph_bus_if gpio_bus ();

    periph_addr_decode i_addr_decode
    (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .be_i     (be_i),
        .wdata_i  (wdata_i),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o),
        .boot_bus (boot_bus.host),
        .gpio_bus (gpio_bus.host)
    );

    periph_bootram i_bootram
    (
        .clk_i (clk_i),
        .bus   (boot_bus.device)
    );

    periph_gpio_regs i_gpio_regs
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .switches_i (switches_i),
        .leds_o     (leds_o),
        .bus        (gpio_bus.device)
    );

endmodule

`default_nettype wire

//--- dv/periph_assertions.sv
// Peripheral subsystem assertions
// Read response and LED update rules, bound to the top level

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_assertions
(
    input wire logic                      clk_i,
    input wire logic                      reset_i,
    input wire logic                      req_i,
    input wire logic                      we_i,
    input wire logic [`PERIPH_ADDR_W-1:0] addr_i,
    input wire logic                      rvalid_i,
    input wire logic [7:0]                leds_i
);
    import periph_pkg::*;

    // Response only for a read one cycle earlier
    rvalid_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
        rvalid_i |-> $past(req_i && !we_i))
        else $error("rvalid_o without a read request in the previous cycle");

    rvalid_low_after_reset: assert property (@(posedge clk_i)
        $past(reset_i) |-> !rvalid_i)
        else $error("rvalid_o high in the cycle after reset");

    // LED register moves only on a write to its offset
    leds_after_write: assert property (@(posedge clk_i) disable iff (reset_i)
        !$stable(leds_i) |->
            $past(reset_i) || $past(req_i && we_i && addr_i[5:3] == GPIO_SWITCH_LED))
        else $error("leds_o changed without a write request");

endmodule

bind periph_top periph_assertions i_periph_assertions
(
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .rvalid_i (rvalid_o),
    .leds_i   (leds_o)
);

`default_nettype wire

//--- dv/periph_tb.sv
// Peripheral subsystem testbench
// Directed tests of the boot RAM, GPIO block, RNG FIFO and error word

`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 3000;  // Several times the full test sequence
    localparam int RAM_WORDS      = 6;
    localparam logic [31:0] RNG_DATA   = `PERIPH_GPIO_BASE + 32'h10;
    localparam logic [31:0] RNG_STATUS = `PERIPH_GPIO_BASE + 32'h18;

    logic        clk_i;
    logic        reset_i;
    logic        req_i;
    logic        we_i;
    logic [31:0] addr_i;
    logic [3:0]  be_i;
    logic [31:0] wdata_i;
    logic [7:0]  switches_i;
    logic [31:0] rdata_o;
    logic        rvalid_o;
    logic [7:0]  leds_o;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    integer      seed;
    logic [31:0] burst_addr [RAM_WORDS];
    logic [31:0] burst_data [RAM_WORDS];
    logic [31:0] ram_model  [RAM_WORDS];  // Expected RAM words

    periph_top i_periph_top
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .be_i       (be_i),
        .wdata_i    (wdata_i),
        .switches_i (switches_i),
        .rdata_o    (rdata_o),
        .rvalid_o   (rvalid_o),
        .leds_o     (leds_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog
    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: tests did not finish within %0d cycles", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Reference models
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ `PERIPH_LFSR_TAPS;
        return state >> 1;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int lane = 0; lane < 4; lane++)
        begin
            if (be[lane])
                result[lane*8 +: 8] = new_word[lane*8 +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------
    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= 1'b1;
        addr_i  <= addr;
        be_i    <= be;
        wdata_i <= data;
        @(posedge clk_i);  // Write lands on this edge
        req_i   <= 1'b0;
        we_i    <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk_i);
        req_i  <= 1'b1;
        we_i   <= 1'b0;
        addr_i <= addr;
        be_i   <= 4'hF;
        @(posedge clk_i);
        req_i  <= 1'b0;
        @(negedge clk_i);
        if (!rvalid_o)
        begin
            $display("No read response in the cycle after the read of %h", addr);
            errors++;
        end
        data = rdata_o;
    endtask

    // One read per cycle with each response sampled a cycle later
    task automatic read_burst(input int n);
        for (int i = 0; i <= n; i++)
        begin
            @(posedge clk_i);
            req_i  <= (i < n);
            we_i   <= 1'b0;
            be_i   <= 4'hF;
            if (i < n)
                addr_i <= burst_addr[i];
            @(negedge clk_i);
            if (i > 0)
            begin
                if (!rvalid_o)
                begin
                    $display("No response for burst read %0d at %h", i - 1, burst_addr[i-1]);
                    errors++;
                end
                burst_data[i-1] = rdata_o;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic reset_state();
        @(negedge clk_i);
        check_value("rvalid_o", 32'(rvalid_o), 32'h0);
        check_value("leds_o", 32'(leds_o), 32'h0);
    endtask

    task automatic bootram_words();
        logic [31:0] new_word;
        logic [31:0] data;
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            burst_addr[i] = `PERIPH_BOOT_BASE + 32'(i) * 32'h84;
            ram_model[i]  = $random(seed);
            bus_write(burst_addr[i], 4'hF, ram_model[i]);
        end
        read_burst(RAM_WORDS);
        for (int i = 0; i < RAM_WORDS; i++)
            check_value("rdata_o", burst_data[i], ram_model[i]);
        new_word = $random(seed);
        bus_write(burst_addr[1], 4'b0101, new_word);  // Lanes 0 and 2 only
        ram_model[1] = merge_bytes(ram_model[1], new_word, 4'b0101);
        bus_read(burst_addr[1], data);
        check_value("rdata_o", data, ram_model[1]);
    endtask

    task automatic gpio_leds_switches();
        logic [31:0] value;
        logic [7:0]  sw;
        logic [31:0] data;
        value = $random(seed);
        bus_write(`PERIPH_GPIO_BASE, 4'b0001, value);
        @(negedge clk_i);
        check_value("leds_o", 32'(leds_o), 32'(value[7:0]));
        bus_write(`PERIPH_GPIO_BASE, 4'b1110, ~value);  // No lane 0 so the LEDs hold
        @(negedge clk_i);
        check_value("leds_o", 32'(leds_o), 32'(value[7:0]));
        sw = 8'($random(seed));
        @(posedge clk_i);
        switches_i <= sw;
        bus_read(`PERIPH_GPIO_BASE, data);
        check_value("rdata_o", data, 32'(sw));
    endtask

    task automatic rng_sequence();
        logic [31:0] expect_state;
        logic [31:0] data;
        repeat (12) @(posedge clk_i);
        bus_read(RNG_STATUS, data);
        check_value("rdata_o", data, 32'h8000_0008);  // Full with count 8
        expect_state = `PERIPH_LFSR_SEED;
        bus_read(RNG_DATA, data);
        check_value("rdata_o", data, expect_state);
        bus_read(RNG_DATA, data);
        check_value("rdata_o", data, expect_state);
        for (int i = 0; i < 12; i++)
        begin
            bus_write(RNG_DATA, 4'hF, 32'h0);
            expect_state = lfsr_step(expect_state);
            bus_read(RNG_DATA, data);
            check_value("rdata_o", data, expect_state);
        end
    endtask

    task automatic unmapped_access();
        logic [31:0] data;
        logic [7:0]  leds_before;
        bus_read(32'h2000_0000, data);
        check_value("rdata_o", data, `PERIPH_ERR_WORD);
        bus_read(`PERIPH_BOOT_BASE + `PERIPH_BOOT_LEN, data);
        check_value("rdata_o", data, `PERIPH_ERR_WORD);
        bus_read(`PERIPH_GPIO_BASE + 32'h08, data);
        check_value("rdata_o", data, `PERIPH_ERR_WORD);
        bus_read(`PERIPH_GPIO_BASE + 32'h20, data);
        check_value("rdata_o", data, `PERIPH_ERR_WORD);
        @(negedge clk_i);
        leds_before = leds_o;
        // Both addresses alias a real word or register in their low bits
        bus_write(`PERIPH_BOOT_BASE + `PERIPH_BOOT_LEN, 4'hF, ~ram_model[0]);
        bus_write(`PERIPH_GPIO_BASE + `PERIPH_GPIO_LEN, 4'hF, 32'(~leds_before));
        bus_read(burst_addr[0], data);
        check_value("rdata_o", data, ram_model[0]);
        check_value("leds_o", 32'(leds_o), 32'(leds_before));
    endtask

    // ------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------
    initial
    begin
        seed       = 76604;
        reset_i    = 1'b1;
        req_i      = 1'b0;
        we_i       = 1'b0;
        addr_i     = '0;
        be_i       = '0;
        wdata_i    = '0;
        switches_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;

        reset_state();
        bootram_words();
        gpio_leds_switches();
        rng_sequence();
        unmapped_access();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/periph_pkg.sv
source/periph_bus_if.sv
source/periph_rng_fifo.sv
source/periph_bootram.sv
source/periph_gpio_regs.sv
source/periph_addr_decode.sv
source/periph_top.sv
dv/periph_assertions.sv
dv/periph_tb.sv

//--- Makefile
TOOL       = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = periph_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
